/* include/rob_settings.svh */
// Sizes are fixed at build time; the index widths must stay equal to log2 of the counts below
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Reorder buffer depth in entries
`define ROB_DEPTH 32

// Bits needed to address one ROB entry
`define ROB_IDX_W 5

// Architectural registers seen by software
`define NUM_LREGS 32

// Physical registers behind the rename map
`define NUM_PREGS 64

// Physical register tag width
`define PREG_W 6

`endif

/* logic/rob_pkg.sv */
// Shared types for the retirement path; field widths follow the macros in rob_settings.svh
`include "rob_settings.svh"

package rob_pkg;

    // Architectural destination number
    typedef logic [$clog2(`NUM_LREGS)-1:0] lreg_t;

    // Physical register tag
    typedef logic [`PREG_W-1:0] preg_t;

    // Slot number inside the reorder buffer
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // What dispatch hands over for one instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        lreg_t       ard;
    } alloc_req_t;

    // One stored ROB slot
    typedef struct packed {
        alloc_req_t req;
        preg_t      prd;      // newly allocated tag
        preg_t      old_prd;  // tag displaced by this write
        logic       valid;
        logic       busy;
    } rob_entry_t;

    // Retirement record, one per commit strobe
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        lreg_t       ard;
        preg_t       prd;
        preg_t       old_prd;
        rob_idx_t    idx;
    } commit_t;

endpackage

/* logic/rob_free_list.sv */
// Holds at most NUM_PREGS tags; pop while empty and push while full are dropped, so callers gate them
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_free_list import rob_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  pop_i,
    input  logic  push_i,
    input  preg_t push_prd_i,
    output preg_t head_prd_o,
    output logic  empty_o
);

    // One extra bit on each pointer tracks wrap
    localparam int PTR_W = `PREG_W + 1;
    // Tags not claimed by the identity map at reset
    localparam int NUM_INIT = `NUM_PREGS - `NUM_LREGS;

    preg_t            tags [`NUM_PREGS];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] count_q;
    logic             pop_ok;
    logic             push_ok;

    // Guard against underflow and overflow
    assign pop_ok  = pop_i && (count_q != '0);
    assign push_ok = push_i && (count_q != PTR_W'(`NUM_PREGS));

    assign empty_o    = (count_q == '0);
    // Head tag is visible before the pop
    assign head_prd_o = tags[head_q[`PREG_W-1:0]];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Preload tags NUM_LREGS..NUM_PREGS-1 in ascending order
            for (int i = 0; i < NUM_INIT; i++) begin
                tags[i] <= preg_t'(`NUM_LREGS + i);
            end
            head_q  <= '0;
            tail_q  <= PTR_W'(NUM_INIT);
            count_q <= PTR_W'(NUM_INIT);
        end else begin
            if (push_ok) begin
                tags[tail_q[`PREG_W-1:0]] <= push_prd_i;
                tail_q <= tail_q + 1'b1;
            end
            if (pop_ok) begin
                head_q <= head_q + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* logic/rob_rename_map.sv */
// Read is combinational and sees the old mapping in the cycle of a write; no checkpoints for recovery
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_rename_map import rob_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  we_i,
    input  lreg_t ard_i,
    input  preg_t new_prd_i,
    output preg_t old_prd_o
);

    // Current logical to physical binding
    preg_t map_q [`NUM_LREGS];

    // Mapping before this cycle's write, goes to the ROB as old_prd
    assign old_prd_o = map_q[ard_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Identity map, logical r maps to physical r
            for (int i = 0; i < `NUM_LREGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else if (we_i) begin
            // New binding seen by the next allocation
            map_q[ard_i] <= new_prd_i;
        end
    end

endmodule

/* logic/rob_buffer.sv */
// No flush or exceptions; completion of an invalid or idle slot is ignored, one commit per clock
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_buffer import rob_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       alloc_i,
    input  alloc_req_t alloc_req_i,
    input  preg_t      alloc_prd_i,
    input  preg_t      old_prd_i,
    input  logic       free_empty_i,
    input  logic       complete_i,
    input  rob_idx_t   complete_idx_i,
    output logic       alloc_fire_o,
    output logic       alloc_ready_o,
    output rob_idx_t   alloc_idx_o,
    output logic       commit_o,
    output commit_t    commit_data_o,
    output logic       empty_o,
    output logic       full_o
);

    // Binary pointers plus a wrap bit
    localparam int PTR_W = `ROB_IDX_W + 1;

    rob_entry_t       entries [`ROB_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    rob_idx_t         head_idx;
    rob_idx_t         tail_idx;
    rob_entry_t       head_entry;
    rob_entry_t       cmpl_entry;
    logic             commit_ready;
    logic             cmpl_ok;

    assign head_idx   = head_q[`ROB_IDX_W-1:0];
    assign tail_idx   = tail_q[`ROB_IDX_W-1:0];
    assign head_entry = entries[head_idx];
    assign cmpl_entry = entries[complete_idx_i];

    // Same slot, same lap means empty
    assign empty_o = (head_q == tail_q);
    // Same slot, different lap means full
    assign full_o  = (head_idx == tail_idx) && (head_q[PTR_W-1] != tail_q[PTR_W-1]);

    // Needs a free slot and a free physical tag
    assign alloc_ready_o = !full_o && !free_empty_i;
    assign alloc_fire_o  = alloc_i && alloc_ready_o;
    assign alloc_idx_o   = tail_idx;

    // Oldest entry finished executing
    assign commit_ready = head_entry.valid && !head_entry.busy;
    // Only a live, still executing slot can complete
    assign cmpl_ok = complete_i && cmpl_entry.valid && cmpl_entry.busy;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Status bits only, payload is don't care while invalid
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].busy  <= 1'b0;
            end
            head_q   <= '0;
            tail_q   <= '0;
            commit_o <= 1'b0;
        end else begin
            // New entry at tail, starts busy
            if (alloc_fire_o) begin
                entries[tail_idx].req     <= alloc_req_i;
                entries[tail_idx].prd     <= alloc_prd_i;
                entries[tail_idx].old_prd <= old_prd_i;
                entries[tail_idx].valid   <= 1'b1;
                entries[tail_idx].busy    <= 1'b1;
                tail_q <= tail_q + 1'b1;
            end

            // Mark done by index
            if (cmpl_ok) begin
                entries[complete_idx_i].busy <= 1'b0;
            end

            // Retire head, the strobe follows one edge later
            commit_o <= commit_ready;
            if (commit_ready) begin
                entries[head_idx].valid <= 1'b0;
                head_q <= head_q + 1'b1;
            end
        end
    end

    // Retirement record captured with the strobe
    always_ff @(posedge clk_i) begin
        if (commit_ready) begin
            commit_data_o.pc      <= head_entry.req.pc;
            commit_data_o.inst    <= head_entry.req.inst;
            commit_data_o.ard     <= head_entry.req.ard;
            commit_data_o.prd     <= head_entry.prd;
            commit_data_o.old_prd <= head_entry.old_prd;
            commit_data_o.idx     <= head_idx;
        end
    end

endmodule

/* logic/rob_top.sv */
// Single dispatch and single commit; alloc strobe is dropped whenever alloc_ready_o is low
`timescale 1ns/1ps

module rob_top import rob_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       alloc_i,
    input  alloc_req_t alloc_req_i,
    input  logic       complete_i,
    input  rob_idx_t   complete_idx_i,
    output logic       alloc_ready_o,
    output rob_idx_t   alloc_idx_o,
    output preg_t      alloc_prd_o,
    output logic       commit_o,
    output commit_t    commit_data_o,
    output logic       empty_o,
    output logic       full_o
);

    logic  alloc_fire;
    logic  free_empty;
    preg_t free_prd;
    preg_t old_prd;

    // Tag offered this cycle
    assign alloc_prd_o = free_prd;

    rob_buffer u_buffer (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .alloc_i        (alloc_i),
        .alloc_req_i    (alloc_req_i),
        .alloc_prd_i    (free_prd),
        .old_prd_i      (old_prd),
        .free_empty_i   (free_empty),
        .complete_i     (complete_i),
        .complete_idx_i (complete_idx_i),
        .alloc_fire_o   (alloc_fire),
        .alloc_ready_o  (alloc_ready_o),
        .alloc_idx_o    (alloc_idx_o),
        .commit_o       (commit_o),
        .commit_data_o  (commit_data_o),
        .empty_o        (empty_o),
        .full_o         (full_o)
    );

    // Written with the popped tag on each accepted allocation
    rob_rename_map u_map (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .we_i      (alloc_fire),
        .ard_i     (alloc_req_i.ard),
        .new_prd_i (free_prd),
        .old_prd_o (old_prd)
    );

    // Displaced tag returns at commit
    rob_free_list u_free_list (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .pop_i      (alloc_fire),
        .push_i     (commit_o),
        .push_prd_i (commit_data_o.old_prd),
        .head_prd_o (free_prd),
        .empty_o    (free_empty)
    );

endmodule

/* sim/rob_sva.sv */
// Bound into every rob_buffer instance; all rules are disabled while reset_i is high
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_sva (
    input logic clk_i,
    input logic reset_i,
    input logic commit_i,
    input logic empty_i,
    input logic full_i,
    input logic alloc_fire_i
);

    // Room for a count of 0 to ROB_DEPTH plus the lagging strobe
    localparam int CNT_W = `ROB_IDX_W + 2;

    // Accepted entries minus commit strobes from earlier cycles
    logic [CNT_W-1:0] seen_q;
    // Entries held in the ROB now
    // Head has already moved for a strobe that is high
    logic [CNT_W-1:0] live;

    assign live = seen_q - CNT_W'(commit_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            seen_q <= '0;
        end else begin
            seen_q <= seen_q + CNT_W'(alloc_fire_i) - CNT_W'(commit_i);
        end
    end

    // Commit strobe lags the head by one edge, so the ROB held an entry a cycle earlier
    commit_needs_entry: assert property (
        @(posedge clk_i) disable iff (reset_i) commit_i |-> !$past(empty_i)
    ) else $error("commit strobe while the ROB was empty before the edge");

    // Both flags follow the counted occupancy, which keeps them exclusive
    full_empty_exclusive: assert property (
        @(posedge clk_i) disable iff (reset_i)
            (empty_i == (live == '0)) && (full_i == (live == CNT_W'(`ROB_DEPTH)))
    ) else $error("full or empty flag disagrees with the counted occupancy");

    // No slot left means no allocation
    no_alloc_when_full: assert property (
        @(posedge clk_i) disable iff (reset_i) alloc_fire_i |-> (live < CNT_W'(`ROB_DEPTH))
    ) else $error("allocation accepted while the ROB was full");

endmodule

bind rob_buffer rob_sva u_sva (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .commit_i     (commit_o),
    .empty_i      (empty_o),
    .full_i       (full_o),
    .alloc_fire_i (alloc_fire_o)
);

/* sim/rob_tb.sv */
// Needs Verilator with --timing and --assert; stimulus from a fixed xorshift seed, checks at negedge
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_tb import rob_pkg::*; ();

    // Tags preloaded into the free list
    localparam int NUM_INIT      = `NUM_PREGS - `NUM_LREGS;
    localparam int RANDOM_CYCLES = 600;

    logic       clk_i;
    logic       reset_i;
    logic       alloc_i;
    alloc_req_t alloc_req_i;
    logic       complete_i;
    rob_idx_t   complete_idx_i;
    logic       alloc_ready_o;
    rob_idx_t   alloc_idx_o;
    preg_t      alloc_prd_o;
    logic       commit_o;
    commit_t    commit_data_o;
    logic       empty_o;
    logic       full_o;

    // Reference model state, owned by the compare process
    preg_t      map_m [`NUM_LREGS];
    preg_t      free_m [$];
    commit_t    order_q [$];
    rob_idx_t   tail_m;
    int         alloc_cnt;
    int         commit_cnt;
    int         recycled_cnt;
    int         mon_errors;

    // Stimulus side
    rob_idx_t   busy_q [$];
    logic       expect_drop;
    logic [31:0] rng;
    int         main_errors;
    int         mark;

    rob_top dut0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .alloc_i        (alloc_i),
        .alloc_req_i    (alloc_req_i),
        .complete_i     (complete_i),
        .complete_idx_i (complete_idx_i),
        .alloc_ready_o  (alloc_ready_o),
        .alloc_idx_o    (alloc_idx_o),
        .alloc_prd_o    (alloc_prd_o),
        .commit_o       (commit_o),
        .commit_data_o  (commit_data_o),
        .empty_o        (empty_o),
        .full_o         (full_o)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Returns 1 on a mismatch after printing it
    function automatic int mismatch(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
        mismatch = 0;
        assert (got === exp) else begin
            $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
            mismatch = 1;
        end
    endfunction

    // Expected retirement record of an accepted allocation
    function automatic commit_t predict_alloc(input alloc_req_t req);
        commit_t c;
        c.pc      = req.pc;
        c.inst    = req.inst;
        c.ard     = req.ard;
        c.prd     = free_m[0];           // free list hands out in FIFO order
        c.old_prd = map_m[req.ard];      // mapping before this write
        c.idx     = tail_m;
        return c;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
        alloc_i    = 1'b0;
        complete_i = 1'b0;
    endtask

    task automatic drive_alloc();
        rng = xorshift(rng);
        alloc_req_i.pc = rng;
        rng = xorshift(rng);
        alloc_req_i.inst = rng;
        // rd field of the instruction word
        alloc_req_i.ard = rng[11:7];
        alloc_i = 1'b1;
        if (alloc_ready_o) begin
            busy_q.push_back(alloc_idx_o);
        end
    endtask

    // Finish one random outstanding entry
    task automatic drive_complete();
        int k;
        rng = xorshift(rng);
        k = int'(rng % 32'(busy_q.size()));
        complete_idx_i = busy_q[k];
        busy_q.delete(k);
        complete_i = 1'b1;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = main_errors + mon_errors - mark;
        $display("%s finished with %0d errors", name, errs);
        mark = mark + errs;
    endtask

    always @(negedge clk_i) begin : compare
        commit_t exp_c;
        commit_t exp_a;
        logic    exp_ready;
        logic    have_freed;
        preg_t   freed;
        if (reset_i) begin
            // Model follows the DUT reset
            for (int i = 0; i < `NUM_LREGS; i++) begin
                map_m[i] = preg_t'(i);
            end
            free_m.delete();
            for (int i = 0; i < NUM_INIT; i++) begin
                free_m.push_back(preg_t'(`NUM_LREGS + i));
            end
            order_q.delete();
            tail_m       = '0;
            alloc_cnt    = 0;
            commit_cnt   = 0;
            recycled_cnt = 0;
            mon_errors   = 0;
        end else begin
            have_freed = 1'b0;
            freed      = '0;
            if (commit_o) begin
                assert (order_q.size() != 0) else begin
                    $display("%0t: commit strobe with no entry outstanding in the model", $time);
                    mon_errors++;
                end
                if (order_q.size() != 0) begin
                    // Oldest allocation must retire first
                    exp_c = order_q.pop_front();
                    mon_errors += mismatch("commit_data_o.pc", commit_data_o.pc, exp_c.pc);
                    mon_errors += mismatch("commit_data_o.inst", commit_data_o.inst, exp_c.inst);
                    mon_errors += mismatch("commit_data_o.ard", 32'(commit_data_o.ard),
                                           32'(exp_c.ard));
                    mon_errors += mismatch("commit_data_o.prd", 32'(commit_data_o.prd),
                                           32'(exp_c.prd));
                    mon_errors += mismatch("commit_data_o.old_prd", 32'(commit_data_o.old_prd),
                                           32'(exp_c.old_prd));
                    mon_errors += mismatch("commit_data_o.idx", 32'(commit_data_o.idx),
                                           32'(exp_c.idx));
                    freed      = exp_c.old_prd;
                    have_freed = 1'b1;
                    commit_cnt++;
                end
            end
            // Head already moved for this commit, but its tag is pushed only at the next edge
            exp_ready = (order_q.size() < `ROB_DEPTH) && (free_m.size() != 0);
            mon_errors += mismatch("alloc_ready_o", 32'(alloc_ready_o), 32'(exp_ready));
            if (alloc_i && !exp_ready) begin
                assert (expect_drop) else begin
                    $display("%0t: allocate strobe given while the ROB was not ready", $time);
                    mon_errors++;
                end
            end
            if (alloc_i && exp_ready) begin
                exp_a = predict_alloc(alloc_req_i);
                mon_errors += mismatch("alloc_idx_o", 32'(alloc_idx_o), 32'(exp_a.idx));
                mon_errors += mismatch("alloc_prd_o", 32'(alloc_prd_o), 32'(exp_a.prd));
                order_q.push_back(exp_a);
                map_m[exp_a.ard] = exp_a.prd;
                void'(free_m.pop_front());
                tail_m = tail_m + 1'b1;
                // Past the preload every tag was released by a commit
                if (alloc_cnt >= NUM_INIT) begin
                    recycled_cnt++;
                end
                alloc_cnt++;
            end
            if (have_freed) begin
                free_m.push_back(freed);
            end
        end
    end

    initial begin : stimulus
        logic drained;
        logic do_cmpl;
        logic do_alloc;
        reset_i        = 1'b1;
        alloc_i        = 1'b0;
        alloc_req_i    = '0;
        complete_i     = 1'b0;
        complete_idx_i = '0;
        expect_drop    = 1'b0;
        rng            = 32'd21958;
        main_errors    = 0;
        mark           = 0;
        repeat (8) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        // Idle state right after reset
        @(negedge clk_i);
        main_errors += mismatch("empty_o", 32'(empty_o), 32'd1);
        main_errors += mismatch("full_o", 32'(full_o), 32'd0);
        main_errors += mismatch("alloc_ready_o", 32'(alloc_ready_o), 32'd1);
        main_errors += mismatch("commit_o", 32'(commit_o), 32'd0);
        main_errors += mismatch("alloc_prd_o", 32'(alloc_prd_o), 32'd32);
        end_test("reset_state");

        // Fill every slot, nothing completes
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            next_cycle();
            drive_alloc();
        end
        next_cycle();
        main_errors += mismatch("full_o", 32'(full_o), 32'd1);
        main_errors += mismatch("alloc_ready_o", 32'(alloc_ready_o), 32'd0);
        // Strobe while full is dropped
        expect_drop = 1'b1;
        drive_alloc();
        next_cycle();
        expect_drop = 1'b0;
        main_errors += mismatch("full_o", 32'(full_o), 32'd1);
        main_errors += mismatch("alloc_idx_o", 32'(alloc_idx_o), 32'd0);
        main_errors += mismatch("empty_o", 32'(empty_o), 32'd0);
        end_test("full_buffer");

        // Random allocate and out of order completion
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            next_cycle();
            rng = xorshift(rng);
            do_cmpl  = (rng[1:0] != 2'b00) && (busy_q.size() != 0);
            do_alloc = rng[2] && alloc_ready_o;
            if (do_cmpl) begin
                drive_complete();
            end
            if (do_alloc) begin
                drive_alloc();
            end
        end
        end_test("random_traffic");

        // Finish whatever is still busy, then wait for the last commit
        while (busy_q.size() != 0) begin
            next_cycle();
            drive_complete();
        end
        drained = 1'b0;
        for (int t = 0; t < 200 && !drained; t++) begin
            next_cycle();
            drained = empty_o && (order_q.size() == 0);
        end
        assert (drained) else begin
            $display("%0t: timeout, the ROB did not drain within 200 cycles", $time);
            main_errors++;
        end
        main_errors += mismatch("commit count", 32'(commit_cnt), 32'(alloc_cnt));
        end_test("drain");

        // Released tags came back through alloc_prd_o
        assert (commit_cnt > `ROB_DEPTH) else begin
            $display("only %0d commits, too few to recycle tags", commit_cnt);
            main_errors++;
        end
        assert (recycled_cnt > 0) else begin
            $display("no released register was handed out again");
            main_errors++;
        end
        end_test("recycling");

        $display("allocations %0d, commits %0d, recycled %0d, errors %0d",
                 alloc_cnt, commit_cnt, recycled_cnt, main_errors + mon_errors);
        if (main_errors + mon_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
logic/rob_pkg.sv
logic/rob_free_list.sv
logic/rob_rename_map.sv
logic/rob_buffer.sv
logic/rob_top.sv
sim/rob_sva.sv
sim/rob_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds with Verilator, runs, and passes only if the testbench printed its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module rob_tb -f tb.f -o rob_sim &&
./obj_dir/rob_sim | tee /dev/stderr | grep -x "Test OK" > /dev/null &&
echo "rob simulation passed" ||
{ echo "rob simulation failed"; exit 1; }
